/* src/fft_tail_pkg.sv */
`default_nettype none

package fft_tail_pkg;

   ////////////////////////////////////////
   // Commutator routing
   ////////////////////////////////////////

   // Pass keeps up on x, cross swaps up and delayed down
   typedef enum logic {
      sw_pass  = 1'b0,
      sw_cross = 1'b1
   } switch_mode_e;

   ////////////////////////////////////////
   // Datapath defaults
   ////////////////////////////////////////

   // Bits per real or imaginary input component
   parameter int default_in_width = 21;

   // Bits per output component
   parameter int default_out_width = 10;

   // Q7.15 down to Q6.4
   parameter int default_frac_drop = 11;

   // Commutator delay in valid samples
   parameter int default_delay = 16;

endpackage

`default_nettype wire

/* src/lane_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One lane's sample pair, re in the upper half and im in the lower half
interface lane_if import fft_tail_pkg::*; #(
   parameter int width = default_in_width
) ();

   logic                 valid;
   logic [2*width-1:0]   up;
   logic [2*width-1:0]   down;
   // Only meaningful after the requantizer
   logic                 sat;

   modport source (
      output valid,
      output up,
      output down,
      output sat
   );

   modport sink (
      input valid,
      input up,
      input down,
      input sat
   );

endinterface

`default_nettype wire

/* src/delay_commutator.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_commutator import fft_tail_pkg::*; #(
   parameter int width = default_in_width,
   parameter int delay = default_delay
) (
   input  wire                clk,
   input  wire                reset,
   input  wire                in_valid,
   input  wire [2*width-1:0]  in_up,
   input  wire [2*width-1:0]  in_down,
   lane_if.source             out
);

   localparam int aw = (delay > 1) ? $clog2(delay) : 1;

   // Circular delay lines, shared write pointer
   logic [2*width-1:0] pre_mem  [delay];
   logic [2*width-1:0] post_mem [delay];

   // Counter modulo 2*delay is {mode, ptr}
   logic [aw-1:0]      ptr;
   switch_mode_e       mode;
   logic               wrap;
   logic               primed;

   logic [2*width-1:0] dd;
   logic [2*width-1:0] x;
   logic [2*width-1:0] y;

   assign wrap = (ptr == aw'(delay - 1));

   // Oldest entry, written delay valid samples ago
   assign dd = pre_mem[ptr];

   ////////////////////////////////////////
   // Switch
   ////////////////////////////////////////

   always_comb begin
      if (mode == sw_pass) begin
         x = in_up;
         y = dd;
      end else begin
         x = dd;
         y = in_up;
      end
   end

   ////////////////////////////////////////
   // Sample counter and priming
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ptr       <= '0;
         mode      <= sw_pass;
         primed    <= 1'b0;
         out.valid <= 1'b0;
      end else begin
         // Nothing leaves until both delay lines hold real data
         out.valid <= in_valid & primed;
         if (in_valid) begin
            if (wrap) begin
               ptr  <= '0;
               mode <= (mode == sw_pass) ? sw_cross : sw_pass;
               // Full period of 2*delay inputs seen
               if (mode == sw_cross) begin
                  primed <= 1'b1;
               end
            end else begin
               ptr <= ptr + aw'(1);
            end
         end
      end
   end

   ////////////////////////////////////////
   // Delay lines and output registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (in_valid) begin
         pre_mem[ptr]  <= in_down;
         post_mem[ptr] <= x;
         // Post-delay read happens before this slot is overwritten
         out.up        <= post_mem[ptr];
         out.down      <= y;
      end
   end

   // No clamping in this stage
   assign out.sat = 1'b0;

endmodule

`default_nettype wire

/* src/radix2_butterfly.sv */
`timescale 1ns/1ps
`default_nettype none

module radix2_butterfly import fft_tail_pkg::*; #(
   parameter int width = default_in_width
) (
   input  wire      clk,
   input  wire      reset,
   lane_if.sink     in,
   lane_if.source   out
);

   localparam int ow = width + 1;

   logic [width-1:0] up_re;
   logic [width-1:0] up_im;
   logic [width-1:0] dn_re;
   logic [width-1:0] dn_im;

   logic [ow-1:0]    sum_re;
   logic [ow-1:0]    sum_im;
   logic [ow-1:0]    dif_re;
   logic [ow-1:0]    dif_im;

   // Split the packed pair into components
   assign up_re = in.up[2*width-1:width];
   assign up_im = in.up[width-1:0];
   assign dn_re = in.down[2*width-1:width];
   assign dn_im = in.down[width-1:0];

   // One guard bit, so no overflow is possible
   assign sum_re = {up_re[width-1], up_re} + {dn_re[width-1], dn_re};
   assign sum_im = {up_im[width-1], up_im} + {dn_im[width-1], dn_im};
   assign dif_re = {up_re[width-1], up_re} - {dn_re[width-1], dn_re};
   assign dif_im = {up_im[width-1], up_im} - {dn_im[width-1], dn_im};

   always_ff @(posedge clk) begin
      if (reset) begin
         out.valid <= 1'b0;
      end else begin
         out.valid <= in.valid;
      end
   end

   // Hold last result while idle
   always_ff @(posedge clk) begin
      if (in.valid) begin
         out.up   <= {sum_re, sum_im};
         out.down <= {dif_re, dif_im};
      end
   end

   assign out.sat = 1'b0;

endmodule

`default_nettype wire

/* src/sat_requant.sv */
`timescale 1ns/1ps
`default_nettype none

module sat_requant import fft_tail_pkg::*; #(
   parameter int in_width  = default_in_width + 1,
   parameter int out_width = default_out_width,
   parameter int frac_drop = default_frac_drop
) (
   input  wire      clk,
   input  wire      reset,
   lane_if.sink     in,
   lane_if.source   out
);

   // Width left after the fraction is dropped
   localparam int tw = in_width - frac_drop;

   ////////////////////////////////////////
   // Per-component requantization
   ////////////////////////////////////////

   // Returns {clamped, value}
   function automatic logic [out_width:0] requant(input logic [in_width-1:0] v);
      logic [tw-1:0]        t;
      logic                 fits;
      logic [out_width-1:0] q;
      // Dropping low bits of two's complement rounds toward minus infinity
      t    = v[in_width-1:frac_drop];
      fits = (t[tw-1:out_width-1] == {(tw - out_width + 1){t[tw-1]}});
      if (fits) begin
         q = t[out_width-1:0];
      end else if (t[tw-1]) begin
         q = {1'b1, {(out_width - 1){1'b0}}};
      end else begin
         q = {1'b0, {(out_width - 1){1'b1}}};
      end
      return {~fits, q};
   endfunction

   logic [out_width:0] up_re;
   logic [out_width:0] up_im;
   logic [out_width:0] dn_re;
   logic [out_width:0] dn_im;
   logic               any_sat;

   assign up_re = requant(in.up[2*in_width-1:in_width]);
   assign up_im = requant(in.up[in_width-1:0]);
   assign dn_re = requant(in.down[2*in_width-1:in_width]);
   assign dn_im = requant(in.down[in_width-1:0]);

   // Any of the four components clamped
   assign any_sat = up_re[out_width] | up_im[out_width] |
                    dn_re[out_width] | dn_im[out_width];

   ////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         out.valid <= 1'b0;
      end else begin
         out.valid <= in.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in.valid) begin
         out.up   <= {up_re[out_width-1:0], up_im[out_width-1:0]};
         out.down <= {dn_re[out_width-1:0], dn_im[out_width-1:0]};
         out.sat  <= any_sat;
      end
   end

endmodule

`default_nettype wire

/* src/fft_tail_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_tail_top import fft_tail_pkg::*; #(
   parameter int in_width  = default_in_width,
   parameter int out_width = default_out_width,
   parameter int frac_drop = default_frac_drop,
   parameter int delay     = default_delay
) (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    in_valid,
   input  wire [2*in_width-1:0]   in0_up,
   input  wire [2*in_width-1:0]   in0_down,
   input  wire [2*in_width-1:0]   in1_up,
   input  wire [2*in_width-1:0]   in1_down,
   output wire                    out_valid,
   output wire [2*out_width-1:0]  out0_up,
   output wire [2*out_width-1:0]  out0_down,
   output wire [2*out_width-1:0]  out1_up,
   output wire [2*out_width-1:0]  out1_down,
   output wire                    out0_sat,
   output wire                    out1_sat
);

   // Commutator to butterfly
   lane_if #(.width(in_width))     cb0 ();
   lane_if #(.width(in_width))     cb1 ();
   // Butterfly to requantizer, one bit of growth
   lane_if #(.width(in_width + 1)) bq0 ();
   lane_if #(.width(in_width + 1)) bq1 ();
   // Requantizer to output ports
   lane_if #(.width(out_width))    qo0 ();
   lane_if #(.width(out_width))    qo1 ();

   ////////////////////////////////////////
   // Lane 0
   ////////////////////////////////////////

   delay_commutator #(.width(in_width), .delay(delay)) u_comm0 (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .in_up    (in0_up),
      .in_down  (in0_down),
      .out      (cb0.source)
   );

   radix2_butterfly #(.width(in_width)) u_bfly0 (
      .clk   (clk),
      .reset (reset),
      .in    (cb0.sink),
      .out   (bq0.source)
   );

   sat_requant #(
      .in_width  (in_width + 1),
      .out_width (out_width),
      .frac_drop (frac_drop)
   ) u_sat0 (
      .clk   (clk),
      .reset (reset),
      .in    (bq0.sink),
      .out   (qo0.source)
   );

   ////////////////////////////////////////
   // Lane 1
   ////////////////////////////////////////

   delay_commutator #(.width(in_width), .delay(delay)) u_comm1 (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .in_up    (in1_up),
      .in_down  (in1_down),
      .out      (cb1.source)
   );

   radix2_butterfly #(.width(in_width)) u_bfly1 (
      .clk   (clk),
      .reset (reset),
      .in    (cb1.sink),
      .out   (bq1.source)
   );

   sat_requant #(
      .in_width  (in_width + 1),
      .out_width (out_width),
      .frac_drop (frac_drop)
   ) u_sat1 (
      .clk   (clk),
      .reset (reset),
      .in    (bq1.sink),
      .out   (qo1.source)
   );

   // Lanes share in_valid, so lane 0 speaks for both
   assign out_valid = qo0.valid;
   assign out0_up   = qo0.up;
   assign out0_down = qo0.down;
   assign out0_sat  = qo0.sat;
   assign out1_up   = qo1.up;
   assign out1_down = qo1.down;
   assign out1_sat  = qo1.sat;

endmodule

`default_nettype wire

/* bench/fft_tail_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_tail_chk import fft_tail_pkg::*; #(
   parameter int out_width = default_out_width
) (
   input wire                    clk,
   input wire                    reset,
   input wire                    in_valid,
   input wire                    out_valid,
   input wire [2*out_width-1:0]  out0_up,
   input wire [2*out_width-1:0]  out0_down,
   input wire                    out0_sat
);

   localparam logic [out_width-1:0] max_val = {1'b0, {(out_width - 1){1'b1}}};
   localparam logic [out_width-1:0] min_val = {1'b1, {(out_width - 1){1'b0}}};

   logic any_extreme;
   int   fail_count = 0;

   function automatic logic extreme(input logic [out_width-1:0] v);
      return (v == max_val) || (v == min_val);
   endfunction

   // At least one clamped component somewhere in the pair
   assign any_extreme = extreme(out0_up[2*out_width-1:out_width]) ||
                        extreme(out0_up[out_width-1:0]) ||
                        extreme(out0_down[2*out_width-1:out_width]) ||
                        extreme(out0_down[out_width-1:0]);

   ////////////////////////////////////////
   // Valid behavior
   ////////////////////////////////////////

   quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
      else begin
         fail_count++;
         $error("out_valid high during reset");
      end

   quiet_after_reset: assert property (@(posedge clk) $fell(reset) |=> !out_valid)
      else begin
         fail_count++;
         $error("out_valid high in the cycle after reset");
      end

   // Three register stages from input to output
   valid_has_source: assert property (
      @(posedge clk) disable iff (reset) out_valid |-> $past(in_valid, 3))
      else begin
         fail_count++;
         $error("out_valid without in_valid three cycles earlier");
      end

   ////////////////////////////////////////
   // Saturation
   ////////////////////////////////////////

   sat_at_extreme: assert property (
      @(posedge clk) disable iff (reset) (out_valid && out0_sat) |-> any_extreme)
      else begin
         fail_count++;
         $error("out0_sat set with no component at a rail");
      end

endmodule

bind fft_tail_top fft_tail_chk #(.out_width(out_width)) u_chk (
   .clk       (clk),
   .reset     (reset),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .out0_up   (out0_up),
   .out0_down (out0_down),
   .out0_sat  (out0_sat)
);

`default_nettype wire

/* bench/fft_tail_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_tail_tb import fft_tail_pkg::*; ();

   localparam int num_rows = 56;
   localparam int cols     = 18;
   localparam int iw       = default_in_width;
   localparam int ow       = default_out_width;
   // Inputs needed before the first output
   localparam int prime    = 2 * default_delay;
   localparam int num_out  = num_rows - prime;
   // At most three idle cycles per row
   localparam int limit    = num_rows * 4 + 200;

   logic               clk;
   logic               reset;
   logic               in_valid;
   logic [2*iw-1:0]    in0_up;
   logic [2*iw-1:0]    in0_down;
   logic [2*iw-1:0]    in1_up;
   logic [2*iw-1:0]    in1_down;
   wire                out_valid;
   wire  [2*ow-1:0]    out0_up;
   wire  [2*ow-1:0]    out0_down;
   wire  [2*ow-1:0]    out1_up;
   wire  [2*ow-1:0]    out1_down;
   wire                out0_sat;
   wire                out1_sat;

   logic [23:0]        vec_mem [num_rows*cols];
   integer             seed;
   int                 errors    = 0;
   int                 out_count = 0;
   int                 accepted;

   fft_tail_top dut0 (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in0_up    (in0_up),
      .in0_down  (in0_down),
      .in1_up    (in1_up),
      .in1_down  (in1_down),
      .out_valid (out_valid),
      .out0_up   (out0_up),
      .out0_down (out0_down),
      .out1_up   (out1_up),
      .out1_down (out1_down),
      .out0_sat  (out0_sat),
      .out1_sat  (out1_sat)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////
   // Vector access
   ////////////////////////////////////////

   // Input pair built from a re column and the im column after it
   function automatic logic [2*iw-1:0] input_pair(int row, int col);
      return {vec_mem[row*cols+col][iw-1:0], vec_mem[row*cols+col+1][iw-1:0]};
   endfunction

   function automatic logic [2*ow-1:0] expected_pair(int row, int col);
      return {vec_mem[row*cols+col][ow-1:0], vec_mem[row*cols+col+1][ow-1:0]};
   endfunction

   task automatic compare_pair(string name, int row, logic [2*ow-1:0] got,
                               logic [2*ow-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns row %0d %s got %h expected %h",
                  $time, row, name, got, exp);
      end
   endtask

   task automatic compare_flag(string name, int row, logic got, logic exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns row %0d %s got %b expected %b",
                  $time, row, name, got, exp);
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin
      int gap;
      seed     = 32'hbae107cd;
      reset    = 1'b1;
      in_valid = 1'b0;
      in0_up   = '0;
      in0_down = '0;
      in1_up   = '0;
      in1_down = '0;
      $readmemh("bench/fft_tail_vectors.txt", vec_mem);
      repeat (4) @(negedge clk);
      reset = 1'b0;
      for (int r = 0; r < num_rows; r++) begin
         gap      = $unsigned($random(seed)) % 4;
         in_valid = 1'b0;
         repeat (gap) @(negedge clk);
         in0_up   = input_pair(r, 0);
         in0_down = input_pair(r, 2);
         in1_up   = input_pair(r, 4);
         in1_down = input_pair(r, 6);
         in_valid = 1'b1;
         @(negedge clk);
      end
      in_valid = 1'b0;
      while (out_count < num_out) @(negedge clk);
      repeat (5) @(negedge clk);
      $display("Summary: %0d of %0d outputs checked, %0d errors, %0d assertion failures",
               out_count, num_out, errors, dut0.u_chk.fail_count);
      if (errors == 0 && dut0.u_chk.fail_count == 0 && out_count == num_out) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         accepted <= 0;
      end else if (in_valid) begin
         accepted <= accepted + 1;
      end
   end

   ////////////////////////////////////////
   // Output checking
   ////////////////////////////////////////

   // Ordered comparison of every valid output pair
   always @(negedge clk) begin
      int row;
      if (reset && out_valid === 1'b1) begin
         errors++;
         $display("out_valid was high while reset was asserted");
      end
      if (!reset && out_valid === 1'b1) begin
         if (accepted <= prime) begin
            errors++;
            $display("An output appeared before %0d inputs were accepted", prime);
         end
         if (out_count >= num_out) begin
            errors++;
            $display("The DUT produced more outputs than there are expected rows");
         end else begin
            row = prime + out_count;
            compare_pair("out0_up", row, out0_up, expected_pair(row, 8));
            compare_pair("out0_down", row, out0_down, expected_pair(row, 10));
            compare_pair("out1_up", row, out1_up, expected_pair(row, 12));
            compare_pair("out1_down", row, out1_down, expected_pair(row, 14));
            compare_flag("out0_sat", row, out0_sat, vec_mem[row*cols+16][0]);
            compare_flag("out1_sat", row, out1_sat, vec_mem[row*cols+17][0]);
         end
         out_count++;
      end
   end

   initial begin
      repeat (limit) @(posedge clk);
      $display("Watchdog expired after %0d cycles with %0d of %0d outputs seen",
               limit, out_count, num_out);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/fft_tail_vectors.txt */
// u0re u0im d0re d0im u1re u1im d1re d1im (21-bit inputs), then expected
// o0u_re o0u_im o0d_re o0d_im o1u_re o1u_im o1d_re o1d_im (10-bit), sat0 sat1
000000 000000 000800 000000 000000 000000 000000 000800 000 000 000 000 000 000 000 000 0 0
012345 054321 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 032000 1e7000 000000 000000 19c000 019000 000 000 000 000 000 000 000 000 0 0
000000 000000 001be8 1fffff 000000 000000 0007ff 000801 000 000 000 000 000 000 000 000 0 0
000000 000000 0c8000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 138000 0abcde 1edcba 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 100000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 0ff800 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 001000 000000 000000 000800 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 00a000 00f000 000000 000000 138000 005000 000 000 000 000 000 000 000 000 0 0
000000 000000 000c4c 000000 000000 000000 000001 1ffffe 000 000 000 000 000 000 000 000 0 0
000000 000000 096000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 096000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
002800 003800 000000 000000 000000 000000 000000 000000 001 000 001 000 000 001 000 001 0 0
000000 000000 077777 111111 1fe800 003000 000000 000000 000 002 000 3fe 001 000 3ff 000 0 0
0fffff 000000 000000 000000 000000 000000 000000 000000 078 3ec 050 3b0 200 03c 0c8 028 0 1
000000 000000 000000 000000 000000 000000 000000 000000 005 3ff 001 3ff 001 000 000 001 0 0
000000 000000 000000 000000 000000 000000 000000 000000 1ff 000 064 000 000 000 000 000 1 0
000000 000000 000000 000000 000000 000000 000000 000000 000 39c 000 200 000 000 000 000 1 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 0aaaaa 155555 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 200 000 200 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 1ff 000 1ff 000 000 000 000 000 0 0
001000 1fe800 000000 000000 004800 000000 000000 000000 007 004 003 00a 009 000 3f7 000 0 0
000000 1ff800 000000 000000 000000 000000 000000 000000 000 3ff 000 001 3fd 006 3fd 006 0 0
0fffff 000000 000000 000000 000000 000000 000000 000000 1ff 000 000 000 000 000 000 000 1 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0
000000 000000 000000 000000 000000 000000 000000 000000 000 000 000 000 000 000 000 000 0 0

/* all.f */
src/fft_tail_pkg.sv
src/lane_if.sv
src/delay_commutator.sv
src/radix2_butterfly.sv
src/sat_requant.sv
src/fft_tail_top.sv
bench/fft_tail_chk.sv
bench/fft_tail_tb.sv
